/* src/cache_consts.svh */
`ifndef CACHE_CONSTS_SVH
`define CACHE_CONSTS_SVH

// address split, word addressed
`define ADDR_W     32
`define TAG_W      20
`define INDEX_W    10
`define OFFSET_W   2

// data path
`define WORD_W     32
`define LINE_WORDS 4   // words per line

// organisation
`define SETS       1024
`define WAYS       2

`endif

/* src/cache_types_pkg.sv */
package cache_types_pkg;

	`include "cache_consts.svh"

	typedef logic [`WORD_W-1:0] word_t;

	// word 0 sits in the low bits
	typedef logic [`LINE_WORDS-1:0][`WORD_W-1:0] line_t;

	typedef struct packed {
		logic [`TAG_W-1:0]    tag;
		logic [`INDEX_W-1:0]  index;
		logic [`OFFSET_W-1:0] offset;   // word within the line
	} addr_fields_t;

	// raw for the memory side, fields for the lookup
	typedef union packed {
		logic [`ADDR_W-1:0] raw;
		addr_fields_t       f;
	} addr_u;

	typedef struct packed {
		logic              valid;
		logic              used;    // most recently used way of the set
		logic              dirty;
		logic [`TAG_W-1:0] tag;
	} tag_entry_t;

endpackage

/* src/cache_fsm_pkg.sv */
package cache_fsm_pkg;

	typedef enum logic [2:0] {
		st_idle,
		st_lookup,
		st_write_back,
		st_refill,
		st_update       // write refilled line and tag
	} fsm_state_t;

	typedef enum logic [1:0] {
		op_none,
		op_read_line,
		op_write_line
	} burst_op_t;

endpackage

/* src/way_ram_if.sv */
`timescale 1ns/1ps
`include "cache_consts.svh"

interface way_ram_if;
	import cache_types_pkg::*;

	logic [`INDEX_W-1:0] index;
	tag_entry_t          tag_wr;
	line_t               line_wr;
	logic                tag_we;
	logic                line_we;
	tag_entry_t          tag_rd;   // registered, one cycle after index
	line_t               line_rd;
	logic                busy;     // reset sweep in progress

	modport ram (
		input  index, tag_wr, line_wr, tag_we, line_we,
		output tag_rd, line_rd, busy
	);

	modport ctrl (
		output index, tag_wr, line_wr, tag_we, line_we,
		input  tag_rd, line_rd, busy
	);

	modport look (input tag_rd, line_rd);

endinterface

/* src/cache_way.sv */
`timescale 1ns/1ps
`include "cache_consts.svh"

module cache_way (
	input logic     clk,
	input logic     reset,
	way_ram_if.ram  ram
);
	import cache_types_pkg::*;

	tag_entry_t          tag_mem [`SETS];
	line_t               line_mem [`SETS];
	tag_entry_t          tag_q;
	line_t               line_q;
	logic                busy;
	logic [`INDEX_W-1:0] sweep_idx;
	logic [`INDEX_W-1:0] wr_idx;
	tag_entry_t          tag_in;
	logic                tag_wen;
	logic                line_wen;

	// walk every set once after reset, writing invalid entries
	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			busy      <= 1'b1;
			sweep_idx <= '0;
		end else if (busy) begin
			sweep_idx <= sweep_idx + 1'b1;
			if (sweep_idx == `INDEX_W'(`SETS-1))
				busy <= 1'b0;
		end
	end

	assign wr_idx   = busy ? sweep_idx : ram.index;
	assign tag_in   = busy ? '0 : ram.tag_wr;
	assign tag_wen  = busy | ram.tag_we;
	assign line_wen = ram.line_we & ~busy;

	// write-first, so a re-read of the same set sees the update
	always_ff @(posedge clk) begin
		if (tag_wen)
			tag_mem[wr_idx] <= tag_in;
		if (line_wen)
			line_mem[wr_idx] <= ram.line_wr;
		tag_q  <= (tag_wen && wr_idx == ram.index) ? tag_in : tag_mem[ram.index];
		line_q <= (line_wen && wr_idx == ram.index) ? ram.line_wr : line_mem[ram.index];
	end

	assign ram.tag_rd  = tag_q;
	assign ram.line_rd = line_q;
	assign ram.busy    = busy;

endmodule

/* src/way_lookup.sv */
`timescale 1ns/1ps

module way_lookup (
	way_ram_if.look                 way0,
	way_ram_if.look                 way1,
	input  cache_types_pkg::addr_u  addr,
	output logic                    hit,
	output logic                    hit_way,
	output logic                    victim_way,
	output logic                    victim_dirty,
	output cache_types_pkg::word_t  rd_word,
	output cache_types_pkg::line_t  hit_line
);
	import cache_types_pkg::*;

	tag_entry_t t0;
	tag_entry_t t1;
	tag_entry_t tv;
	logic       hit0;
	logic       hit1;

	assign t0 = way0.tag_rd;
	assign t1 = way1.tag_rd;

	assign hit0    = t0.valid && (t0.tag == addr.f.tag);
	assign hit1    = t1.valid && (t1.tag == addr.f.tag);
	assign hit     = hit0 | hit1;
	assign hit_way = ~hit0 & hit1;      // way 0 wins, a double hit cannot happen anyway

	assign hit_line = hit_way ? way1.line_rd : way0.line_rd;
	assign rd_word  = hit_line[addr.f.offset];

	// first invalid way, else the one not used last
	always_comb begin
		if (!t0.valid)
			victim_way = 1'b0;
		else if (!t1.valid)
			victim_way = 1'b1;
		else
			victim_way = t0.used;
	end

	assign tv           = victim_way ? t1 : t0;
	assign victim_dirty = tv.valid & tv.dirty;

endmodule

/* src/mem_burst.sv */
`timescale 1ns/1ps
`include "cache_consts.svh"

module mem_burst (
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       start,
	input  cache_fsm_pkg::burst_op_t   op,
	input  logic [`ADDR_W-1:0]         line_addr,
	input  cache_types_pkg::line_t     wr_line,
	output logic                       done,
	output cache_types_pkg::line_t     rd_line,
	output logic                       read_mem,
	output logic                       write_mem,
	output logic [`ADDR_W-1:0]         addr_mem,
	input  cache_types_pkg::word_t     data_mem,
	output cache_types_pkg::word_t     wdata_mem,
	input  logic                       ready_mem
);
	import cache_types_pkg::*;
	import cache_fsm_pkg::*;

	logic [`OFFSET_W-1:0] cnt;       // words moved so far
	line_t                shift;
	logic                 active;
	logic                 xfer;

	assign active = read_mem | write_mem;
	assign xfer   = active & ready_mem;   // ready low holds everything as is

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			read_mem  <= 1'b0;
			write_mem <= 1'b0;
			cnt       <= '0;
			done      <= 1'b0;
		end else begin
			done <= 1'b0;
			if (start && !active) begin
				read_mem  <= (op == op_read_line);
				write_mem <= (op == op_write_line);
				cnt       <= '0;
			end else if (xfer) begin
				cnt <= cnt + 1'b1;
				if (cnt == `OFFSET_W'(`LINE_WORDS-1)) begin   // last word
					read_mem  <= 1'b0;
					write_mem <= 1'b0;
					done      <= 1'b1;
				end
			end
		end
	end

	// words enter at the top and leave at the bottom, ascending offset
	always_ff @(posedge clk) begin
		if (start && !active) begin
			addr_mem <= line_addr;
			shift    <= wr_line;
		end else if (xfer) begin
			if (read_mem)
				shift <= {data_mem, shift[`LINE_WORDS-1:1]};
			else
				shift <= {`WORD_W'(0), shift[`LINE_WORDS-1:1]};
		end
	end

	assign wdata_mem = shift[0];
	assign rd_line   = shift;    // holds after done until the next start

endmodule

/* src/cache_fsm.sv */
`timescale 1ns/1ps
`include "cache_consts.svh"

module cache_fsm (
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       read_up,
	input  logic                       write_up,
	input  logic [`ADDR_W-1:0]         addr_up,
	input  cache_types_pkg::word_t     wdata_up,
	output logic                       stall_up,
	output cache_types_pkg::word_t     rdata_up,
	output cache_types_pkg::addr_u     req_addr,
	way_ram_if.ctrl                    way0,
	way_ram_if.ctrl                    way1,
	input  logic                       hit,
	input  logic                       hit_way,
	input  logic                       victim_way,
	input  logic                       victim_dirty,
	input  cache_types_pkg::word_t     rd_word,
	input  cache_types_pkg::line_t     hit_line,
	output logic                       burst_start,
	output cache_fsm_pkg::burst_op_t   burst_op,
	output logic [`ADDR_W-1:0]         burst_addr,
	output cache_types_pkg::line_t     burst_line,
	input  logic                       burst_done,
	input  cache_types_pkg::line_t     burst_rd_line
);
	import cache_types_pkg::*;
	import cache_fsm_pkg::*;

	fsm_state_t          state;
	logic                stall_q;
	logic                accept;
	logic                is_write;
	logic                fill_way;
	word_t               wdata_q;
	addr_u               addr_in;
	logic [`INDEX_W-1:0] idx;
	tag_entry_t          victim_tag;
	line_t               merged_line;
	line_t               line_wr;
	tag_entry_t          tag_rd [`WAYS];
	tag_entry_t          tag_wr [`WAYS];
	logic                tag_we [`WAYS];
	logic                line_we [`WAYS];

	assign addr_in  = addr_up;
	assign accept   = (state == st_idle) && !way0.busy && !way1.busy && (read_up || write_up);
	assign stall_up = stall_q | way0.busy | way1.busy;

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			state   <= st_idle;
			stall_q <= 1'b0;
		end else begin
			case (state)
				st_idle: begin
					if (accept) begin
						state   <= st_lookup;
						stall_q <= 1'b1;
					end
				end
				st_lookup: begin
					if (hit) begin
						state   <= st_idle;
						stall_q <= 1'b0;
					end else if (victim_dirty) begin
						state <= st_write_back;
					end else begin
						state <= st_refill;
					end
				end
				st_write_back: if (burst_done) state <= st_refill;
				st_refill:     if (burst_done) state <= st_update;
				st_update:     state <= st_lookup;   // retry that now completes as a hit
				default:       state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			req_addr <= addr_in;
			is_write <= write_up;
			wdata_q  <= wdata_up;
		end
		if (state == st_lookup && !hit)
			fill_way <= victim_way;
		if (state == st_lookup && hit && !is_write)
			rdata_up <= rd_word;
	end

	// index comes straight from the port while idle so the RAM read starts with the strobe
	assign idx        = (state == st_idle) ? addr_in.f.index : req_addr.f.index;
	assign tag_rd[0]  = way0.tag_rd;
	assign tag_rd[1]  = way1.tag_rd;
	assign victim_tag = victim_way ? tag_rd[1] : tag_rd[0];

	always_comb begin
		merged_line = hit_line;
		merged_line[req_addr.f.offset] = wdata_q;
	end

	assign line_wr = (state == st_update) ? burst_rd_line : merged_line;

	// used bit follows the accessed way and the other way is cleared
	always_comb begin
		for (int w = 0; w < `WAYS; w++) begin
			tag_wr[w]  = tag_rd[w];
			tag_we[w]  = 1'b0;
			line_we[w] = 1'b0;
			if (state == st_lookup && hit) begin
				tag_we[w]      = 1'b1;
				tag_wr[w].used = (hit_way == w[0]);
				if (hit_way == w[0] && is_write) begin
					tag_wr[w].dirty = 1'b1;
					line_we[w]      = 1'b1;
				end
			end else if (state == st_update) begin
				tag_we[w]      = 1'b1;
				tag_wr[w].used = 1'b0;
				if (fill_way == w[0]) begin
					tag_wr[w]  = '{valid: 1'b1, used: 1'b1, dirty: 1'b0, tag: req_addr.f.tag};
					line_we[w] = 1'b1;
				end
			end
		end
	end

	always_comb begin
		burst_start = 1'b0;
		burst_op    = op_none;
		burst_addr  = {req_addr.raw[`ADDR_W-1:`OFFSET_W], {`OFFSET_W{1'b0}}};
		if (state == st_lookup && !hit) begin
			burst_start = 1'b1;
			if (victim_dirty) begin
				burst_op   = op_write_line;
				burst_addr = {victim_tag.tag, req_addr.f.index, {`OFFSET_W{1'b0}}};
			end else begin
				burst_op = op_read_line;
			end
		end else if (state == st_write_back && burst_done) begin
			burst_start = 1'b1;     // fetch the new line once the write-back is done
			burst_op    = op_read_line;
		end
	end

	assign burst_line = victim_way ? way1.line_rd : way0.line_rd;

	assign way0.index   = idx;
	assign way0.tag_wr  = tag_wr[0];
	assign way0.tag_we  = tag_we[0];
	assign way0.line_wr = line_wr;
	assign way0.line_we = line_we[0];
	assign way1.index   = idx;
	assign way1.tag_wr  = tag_wr[1];
	assign way1.tag_we  = tag_we[1];
	assign way1.line_wr = line_wr;
	assign way1.line_we = line_we[1];

endmodule

/* src/cache_top.sv */
`timescale 1ns/1ps
`include "cache_consts.svh"

module cache_top (
	input  logic               clk,
	input  logic               reset,
	input  logic               read_up,
	input  logic               write_up,
	input  logic [`ADDR_W-1:0] addr_up,
	input  logic [`WORD_W-1:0] wdata_up,
	output logic [`WORD_W-1:0] rdata_up,
	output logic               stall_up,
	output logic               read_mem,
	output logic               write_mem,
	output logic [`ADDR_W-1:0] addr_mem,
	input  logic [`WORD_W-1:0] data_mem,
	output logic [`WORD_W-1:0] wdata_mem,
	input  logic               ready_mem
);
	import cache_types_pkg::*;
	import cache_fsm_pkg::*;

	addr_u              req_addr;
	logic               hit;
	logic               hit_way;
	logic               victim_way;
	logic               victim_dirty;
	word_t              rd_word;
	line_t              hit_line;
	logic               burst_start;
	burst_op_t          burst_op;
	logic [`ADDR_W-1:0] burst_addr;
	line_t              burst_line;
	logic               burst_done;
	line_t              burst_rd_line;

	way_ram_if w0_if ();
	way_ram_if w1_if ();

	cache_way u_way0 (.clk(clk), .reset(reset), .ram(w0_if.ram));
	cache_way u_way1 (.clk(clk), .reset(reset), .ram(w1_if.ram));

	way_lookup u_lookup (
		.way0(w0_if.look), .way1(w1_if.look), .addr(req_addr),
		.hit(hit), .hit_way(hit_way), .victim_way(victim_way),
		.victim_dirty(victim_dirty), .rd_word(rd_word), .hit_line(hit_line)
	);

	mem_burst u_burst (
		.clk(clk), .reset(reset), .start(burst_start), .op(burst_op),
		.line_addr(burst_addr), .wr_line(burst_line), .done(burst_done),
		.rd_line(burst_rd_line), .read_mem(read_mem), .write_mem(write_mem),
		.addr_mem(addr_mem), .data_mem(data_mem), .wdata_mem(wdata_mem),
		.ready_mem(ready_mem)
	);

	cache_fsm u_fsm (
		.clk(clk), .reset(reset), .read_up(read_up), .write_up(write_up),
		.addr_up(addr_up), .wdata_up(wdata_up), .stall_up(stall_up),
		.rdata_up(rdata_up), .req_addr(req_addr),
		.way0(w0_if.ctrl), .way1(w1_if.ctrl),
		.hit(hit), .hit_way(hit_way), .victim_way(victim_way),
		.victim_dirty(victim_dirty), .rd_word(rd_word), .hit_line(hit_line),
		.burst_start(burst_start), .burst_op(burst_op), .burst_addr(burst_addr),
		.burst_line(burst_line), .burst_done(burst_done), .burst_rd_line(burst_rd_line)
	);

endmodule

/* test/cache_mem_model.sv */
`timescale 1ns/1ps

module cache_mem_model (
	input  logic        clk,
	input  logic [15:0] ready_pat,   // ready_mem sequence, repeats every 16 cycles
	input  logic        read_mem,
	input  logic        write_mem,
	input  logic [31:0] addr_mem,
	input  logic [31:0] wdata_mem,
	output logic [31:0] data_mem,
	output logic        ready_mem
);
	logic [31:0] mem [logic [31:0]];   // written words only
	logic [1:0]  cnt;                  // word within the current burst
	logic [3:0]  pos;

	// unwritten words follow the fill rule
	function automatic logic [31:0] word_at(input logic [31:0] a);
		if (mem.exists(a))
			return mem[a];
		return a ^ 32'h5A5A0000;
	endfunction

	initial begin
		cnt       = 2'd0;
		pos       = 4'd0;
		ready_mem = 1'b0;
		data_mem  = 32'd0;
	end

	always @(posedge clk) begin
		if (read_mem || write_mem) begin
			if (ready_mem) begin
				if (write_mem)
					mem[addr_mem + {30'd0, cnt}] = wdata_mem;
				cnt = cnt + 2'd1;
			end
		end else begin
			cnt = 2'd0;
		end
		#2;
		ready_mem = ready_pat[pos];
		pos       = pos + 4'd1;
		data_mem  = word_at(addr_mem + {30'd0, cnt});   // word for the next transfer
	end

endmodule

/* test/tb_cache.sv */
`timescale 1ns/1ps

module tb_cache;

	logic        clk;
	logic        reset;
	logic        read_up;
	logic        write_up;
	logic [31:0] addr_up;
	logic [31:0] wdata_up;
	logic [31:0] rdata_up;
	logic        stall_up;
	logic        read_mem;
	logic        write_mem;
	logic [31:0] addr_mem;
	logic [31:0] data_mem;
	logic [31:0] wdata_mem;
	logic        ready_mem;
	logic [15:0] ready_pat;
	logic [15:0] lfsr_state;

	logic [31:0] ref_mem [logic [31:0]];   // expected contents of written words
	logic [31:0] rd_lines[$];              // start address of each read burst
	logic [31:0] wb_lines[$];              // start address of each write burst
	logic [31:0] wb_addrs[$];              // every word written to memory
	logic [31:0] wb_words[$];
	logic [31:0] wb_cnt;
	logic        read_prev;
	logic        write_prev;
	string       cur_test;
	int          test_errs;
	int          tests_run;
	int          tests_failed;

	cache_top UUT (
		.clk(clk), .reset(reset), .read_up(read_up), .write_up(write_up),
		.addr_up(addr_up), .wdata_up(wdata_up), .rdata_up(rdata_up), .stall_up(stall_up),
		.read_mem(read_mem), .write_mem(write_mem), .addr_mem(addr_mem),
		.data_mem(data_mem), .wdata_mem(wdata_mem), .ready_mem(ready_mem)
	);

	cache_mem_model u_mem (
		.clk(clk), .ready_pat(ready_pat), .read_mem(read_mem), .write_mem(write_mem),
		.addr_mem(addr_mem), .wdata_mem(wdata_mem), .data_mem(data_mem),
		.ready_mem(ready_mem)
	);

	always #10 clk = ~clk;

	// watch the memory port for bursts
	always @(posedge clk) begin
		if (read_mem && !read_prev)
			rd_lines.push_back(addr_mem);
		if (write_mem && !write_prev)
			wb_lines.push_back(addr_mem);
		if (!write_mem) begin
			wb_cnt = 32'd0;
		end else if (ready_mem) begin
			wb_addrs.push_back(addr_mem + wb_cnt);
			wb_words.push_back(wdata_mem);
			wb_cnt = wb_cnt + 32'd1;
		end
		read_prev  = read_mem;
		write_prev = write_mem;
	end

	// fibonacci lfsr with taps 16 14 13 11
	function automatic logic next_bit();
		logic fb;
		fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
		lfsr_state = {lfsr_state[14:0], fb};
		return fb;
	endfunction

	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = 32'd0;
		for (int i = 0; i < n; i++)
			v = {v[30:0], next_bit()};
		return v;
	endfunction

	function automatic logic [31:0] expected_word(input logic [31:0] a);
		if (ref_mem.exists(a))
			return ref_mem[a];
		return a ^ 32'h5A5A0000;   // memory fill rule
	endfunction

	function automatic logic [31:0] make_addr(input logic [19:0] tag, input logic [9:0] idx,
			input logic [1:0] off);
		return {tag, idx, off};
	endfunction

	// one processor access that waits for stall_up to fall
	task automatic access(input logic wr, input logic [31:0] addr, input logic [31:0] data,
			output logic [31:0] rdata, output logic ok);
		int n;
		ok    = 1'b0;
		rdata = 32'd0;
		n     = 0;
		while (stall_up !== 1'b0 && n < 200) begin
			@(posedge clk);
			#2;
			n++;
		end
		if (stall_up !== 1'b0) begin
			$display("%s: cache still stalled, access to %h not issued", cur_test, addr);
			test_errs++;
			return;
		end
		read_up  = ~wr;
		write_up = wr;
		addr_up  = addr;
		wdata_up = data;
		if (wr)
			ref_mem[addr] = data;
		@(posedge clk);
		#2;
		read_up  = 1'b0;
		write_up = 1'b0;
		if (stall_up !== 1'b1) begin
			$display("%s: strobe for %h not accepted, stall_up stayed low", cur_test, addr);
			test_errs++;
			return;
		end
		n = 0;
		while (stall_up !== 1'b0 && n < 400) begin
			@(posedge clk);
			#2;
			n++;
		end
		if (stall_up !== 1'b0) begin
			$display("%s: access to %h never finished, stall_up stuck high", cur_test, addr);
			test_errs++;
			return;
		end
		rdata = rdata_up;
		ok    = 1'b1;
	endtask

	task automatic finish_test();
		tests_run++;
		if (test_errs == 0) begin
			$display("test %s passed", cur_test);
		end else begin
			$display("test %s failed with %0d errors", cur_test, test_errs);
			tests_failed++;
		end
		test_errs = 0;
	endtask

	task automatic reset_sweep();
		int   n;
		logic req_seen;
		cur_test = "reset";
		n        = 0;
		req_seen = 1'b0;
		if (read_mem !== 1'b0 || write_mem !== 1'b0) begin
			$display("%s: memory request active right after reset", cur_test);
			test_errs++;
		end
		while (stall_up !== 1'b0 && n < 1500) begin   // tag sweep takes one cycle per set
			@(posedge clk);
			#2;
			n++;
			if (read_mem !== 1'b0 || write_mem !== 1'b0)
				req_seen = 1'b1;
		end
		if (stall_up !== 1'b0) begin
			$display("%s: reset sweep did not finish, stall_up still high", cur_test);
			test_errs++;
		end
		if (req_seen) begin
			$display("%s: memory request raised during the reset sweep", cur_test);
			test_errs++;
		end
		finish_test();
	endtask

	task automatic read_miss_then_hit();
		logic [31:0] a;
		logic [31:0] got;
		logic        ok;
		int          n0;
		cur_test = "read_miss_hit";
		a        = make_addr(20'h00012, 10'h005, 2'd2);
		n0       = rd_lines.size();
		access(1'b0, a, 32'd0, got, ok);
		if (ok && got !== expected_word(a)) begin
			$display("Fail %s: expected %h, actual %h", cur_test, expected_word(a), got);
			test_errs++;
		end
		if (rd_lines.size() != n0 + 1) begin
			$display("Fail %s: expected 1 read burst, actual %0d", cur_test,
				rd_lines.size() - n0);
			test_errs++;
		end else if (rd_lines[n0] !== {a[31:2], 2'b00}) begin
			$display("Fail %s: expected %h, actual %h", cur_test, {a[31:2], 2'b00},
				rd_lines[n0]);
			test_errs++;
		end
		access(1'b0, a, 32'd0, got, ok);   // now a hit
		if (ok && got !== expected_word(a)) begin
			$display("Fail %s: expected %h, actual %h", cur_test, expected_word(a), got);
			test_errs++;
		end
		if (rd_lines.size() != n0 + 1) begin
			$display("%s: second read of the same address went to memory", cur_test);
			test_errs++;
		end
		finish_test();
	endtask

	task automatic write_then_read();
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] got;
		logic        ok;
		cur_test = "write_read";
		a        = make_addr(20'h00034, 10'h009, 2'd1);
		access(1'b1, a, 32'hCAFE0001, got, ok);
		for (int off = 0; off < 4; off++) begin
			b = {a[31:2], off[1:0]};
			access(1'b0, b, 32'd0, got, ok);
			if (ok && got !== expected_word(b)) begin
				$display("Fail %s: expected %h, actual %h", cur_test, expected_word(b), got);
				test_errs++;
			end
		end
		finish_test();
	endtask

	// A dirties one way and B fills the other so C must push A out
	task automatic dirty_eviction();
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c;
		logic [31:0] got;
		logic [31:0] sent;
		logic        ok;
		logic        line_seen;
		logic        word_seen;
		int          n0;
		int          w0;
		cur_test  = "dirty_evict";
		a         = make_addr(20'h00100, 10'h021, 2'd2);
		b         = make_addr(20'h00200, 10'h021, 2'd0);
		c         = make_addr(20'h00300, 10'h021, 2'd0);
		n0        = wb_lines.size();
		w0        = wb_addrs.size();
		line_seen = 1'b0;
		word_seen = 1'b0;
		sent      = 32'd0;
		access(1'b1, a, 32'h12345678, got, ok);
		access(1'b0, b, 32'd0, got, ok);
		if (ok && got !== expected_word(b)) begin
			$display("Fail %s: expected %h, actual %h", cur_test, expected_word(b), got);
			test_errs++;
		end
		access(1'b0, c, 32'd0, got, ok);
		if (ok && got !== expected_word(c)) begin
			$display("Fail %s: expected %h, actual %h", cur_test, expected_word(c), got);
			test_errs++;
		end
		for (int i = n0; i < wb_lines.size(); i++)
			if (wb_lines[i] == {a[31:2], 2'b00})
				line_seen = 1'b1;
		for (int i = w0; i < wb_addrs.size(); i++) begin
			if (wb_addrs[i] == a) begin
				word_seen = 1'b1;
				sent      = wb_words[i];
			end
		end
		if (!line_seen) begin
			$display("%s: no write-back burst to line %h", cur_test, {a[31:2], 2'b00});
			test_errs++;
		end
		if (!word_seen) begin
			$display("%s: written word at %h never reached memory", cur_test, a);
			test_errs++;
		end else if (sent !== 32'h12345678) begin
			$display("Fail %s: expected %h, actual %h", cur_test, 32'h12345678, sent);
			test_errs++;
		end
		access(1'b0, a, 32'd0, got, ok);
		if (ok && got !== expected_word(a)) begin
			$display("Fail %s: expected %h, actual %h", cur_test, expected_word(a), got);
			test_errs++;
		end
		finish_test();
	endtask

	task automatic random_traffic();
		logic [31:0] bits;
		logic [31:0] a;
		logic [31:0] d;
		logic [31:0] got;
		logic        ok;
		cur_test = "random";
		for (int i = 0; i < 60; i++) begin
			bits = take_bits(7);   // write flag, tag, index, offset
			a    = make_addr(20'h00500 | {18'd0, bits[5:4]}, 10'h040 | {8'd0, bits[3:2]},
				bits[1:0]);
			d    = take_bits(32);
			access(bits[6], a, d, got, ok);
			if (!bits[6] && ok && got !== expected_word(a)) begin
				$display("Fail %s: read of %h expected %h, actual %h", cur_test, a,
					expected_word(a), got);
				test_errs++;
			end
		end
		finish_test();
	endtask

	initial begin
		logic [31:0] bits;
		clk          = 1'b0;
		reset        = 1'b1;
		read_up      = 1'b0;
		write_up     = 1'b0;
		addr_up      = 32'd0;
		wdata_up     = 32'd0;
		read_prev    = 1'b0;
		write_prev   = 1'b0;
		wb_cnt       = 32'd0;
		test_errs    = 0;
		tests_run    = 0;
		tests_failed = 0;
		lfsr_state   = 16'd29;
		bits         = take_bits(16);
		ready_pat    = bits[15:0] | 16'h0001;   // at least one ready per period
		#2;
		reset = 1'b0;
		repeat (16) @(posedge clk);
		#2;
		reset = 1'b1;

		reset_sweep();
		read_miss_then_hit();
		write_then_read();
		dirty_eviction();
		random_traffic();

		$display("%0d tests run, %0d passed, %0d failed", tests_run,
			tests_run - tests_failed, tests_failed);
		if (tests_failed == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

/* all.f */
+incdir+src
src/cache_types_pkg.sv
src/cache_fsm_pkg.sv
src/way_ram_if.sv
src/cache_way.sv
src/way_lookup.sv
src/mem_burst.sv
src/cache_fsm.sv
src/cache_top.sv
test/cache_mem_model.sv
test/tb_cache.sv

/* Makefile */
SRCS := $(filter-out +%,$(shell cat all.f)) src/cache_consts.svh

.PHONY: run clean

obj_dir/Vtb_cache: all.f $(SRCS)
	verilator --binary --timing -f all.f --top-module tb_cache

run: obj_dir/Vtb_cache
	@out="$$(./obj_dir/Vtb_cache)"; echo "$$out"; \
	echo "$$out" | grep -qx "Simulation finished: PASS"

clean:
	rm -rf obj_dir
